// ==== processorPipeline.f ====
+incdir+source
source/pipelinePkg.sv
source/pipeStageIf.sv
source/controlDecoder.sv
source/registerFile.sv
source/executeStage.sv
source/memoryStage.sv
source/processorPipeline.sv
test/processorPipelineTb.sv

// ==== source/controlDecoder.sv ====
`timescale 1ns/1ps
`include "pipeline_settings.svh"

module controlDecoder
    import pipelinePkg::*;
(
    input  wordT  instr,
    idExIf.source ctrl,
    input  logic  instrValid
);

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];

    always_comb begin
        // Defaults describe a bubble
        ctrl.valid    = instrValid;
        ctrl.aluOp    = `ALU_ADD;
        ctrl.aluSrc   = 1'b0;
        ctrl.shamt    = instr[10:6];
        ctrl.imm      = {{(`DATA_WIDTH-16){instr[15]}}, instr[15:0]};
        ctrl.destReg  = instr[15:11];
        ctrl.regWrite = 1'b0;
        ctrl.memRead  = 1'b0;
        ctrl.memWrite = 1'b0;
        ctrl.wbSel    = 1'b0;

        case (opcode)
            `OP_RTYPE: begin
                ctrl.regWrite = 1'b1;
                case (funct)
                    `FUNCT_ADD: ctrl.aluOp = `ALU_ADD;
                    `FUNCT_SUB: ctrl.aluOp = `ALU_SUB;
                    `FUNCT_AND: ctrl.aluOp = `ALU_AND;
                    `FUNCT_OR:  ctrl.aluOp = `ALU_OR;
                    `FUNCT_SLT: ctrl.aluOp = `ALU_SLT;
                    `FUNCT_SLL: ctrl.aluOp = `ALU_SLL;
                    default:    ctrl.regWrite = 1'b0;
                endcase
            end
            `OP_ADDI, `OP_SLTI, `OP_ANDI, `OP_ORI: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.destReg  = instr[20:16];
                ctrl.regWrite = 1'b1;
                if (opcode == `OP_SLTI) begin
                    ctrl.aluOp = `ALU_SLT;
                end else if (opcode == `OP_ANDI) begin
                    ctrl.aluOp = `ALU_AND;
                end else if (opcode == `OP_ORI) begin
                    ctrl.aluOp = `ALU_OR;
                end
                // Logical immediates are zero extended
                if (opcode == `OP_ANDI || opcode == `OP_ORI) begin
                    ctrl.imm = {{(`DATA_WIDTH-16){1'b0}}, instr[15:0]};
                end
            end
            `OP_LW: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.destReg  = instr[20:16];
                ctrl.regWrite = 1'b1;
                ctrl.memRead  = 1'b1;
                ctrl.wbSel    = 1'b1;
            end
            `OP_SW: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memWrite = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

// ==== source/executeStage.sv ====
`timescale 1ns/1ps
`include "pipeline_settings.svh"

module executeStage
    import pipelinePkg::*;
(
    input  logic   Clk,
    input  logic   arstN,
    idExIf.sink    dec,
    exMemIf.source exMem
);

    logic    exValid;
    logic    exRegWrite;
    logic    exMemRead;
    logic    exMemWrite;
    aluOpT   exAluOp;
    logic    exAluSrc;
    shamtT   exShamt;
    wordT    exImm;
    wordT    exReadData1;
    wordT    exReadData2;
    regAddrT exDestReg;
    wbSelT   exWbSel;
    wordT    operandB;
    wordT    aluResult;

    ////////////////////
    // ID/EX register
    ////////////////////

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            exValid    <= 1'b0;
            exRegWrite <= 1'b0;
            exMemRead  <= 1'b0;
            exMemWrite <= 1'b0;
        end else begin
            exValid    <= dec.valid;
            exRegWrite <= dec.regWrite;
            exMemRead  <= dec.memRead;
            exMemWrite <= dec.memWrite;
        end
    end

    always_ff @(posedge Clk) begin
        exAluOp     <= dec.aluOp;
        exAluSrc    <= dec.aluSrc;
        exShamt     <= dec.shamt;
        exImm       <= dec.imm;
        exReadData1 <= dec.readData1;
        exReadData2 <= dec.readData2;
        exDestReg   <= dec.destReg;
        exWbSel     <= dec.wbSel;
    end

    ////////////////////
    // ALU
    ////////////////////

    assign operandB = exAluSrc ? exImm : exReadData2;

    always_comb begin
        case (exAluOp)
            `ALU_ADD: aluResult = exReadData1 + operandB;
            `ALU_SUB: aluResult = exReadData1 - operandB;
            `ALU_AND: aluResult = exReadData1 & operandB;
            `ALU_OR:  aluResult = exReadData1 | operandB;
            `ALU_SLT: aluResult = {{(`DATA_WIDTH-1){1'b0}},
                                   $signed(exReadData1) < $signed(operandB)};
            // Shift source is rt, as in MIPS sll
            `ALU_SLL: aluResult = exReadData2 << exShamt;
            default:  aluResult = '0;
        endcase
    end

    ////////////////////
    // EX/MEM register
    ////////////////////

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            exMem.valid    <= 1'b0;
            exMem.regWrite <= 1'b0;
            exMem.memRead  <= 1'b0;
            exMem.memWrite <= 1'b0;
        end else begin
            exMem.valid    <= exValid;
            exMem.regWrite <= exRegWrite;
            exMem.memRead  <= exMemRead;
            exMem.memWrite <= exMemWrite;
        end
    end

    always_ff @(posedge Clk) begin
        exMem.aluResult <= aluResult;
        exMem.storeData <= exReadData2;
        exMem.destReg   <= exDestReg;
        exMem.wbSel     <= exWbSel;
    end

endmodule

// ==== source/memoryStage.sv ====
`timescale 1ns/1ps
`include "pipeline_settings.svh"

module memoryStage
    import pipelinePkg::*;
(
    input  logic    Clk,
    input  logic    arstN,
    exMemIf.sink    exMem,
    output logic    wbValid,
    output regAddrT wbReg,
    output wordT    wbData
);

    wordT dataMem [0:(2**`DMEM_ADDR_WIDTH)-1];

    logic [`DMEM_ADDR_WIDTH-1:0] memIndex;
    wordT                        loadData;
    logic                        wbWrite;
    wordT                        wbAluResult;
    wordT                        wbLoadData;
    wbSelT                       wbSelQ;

    ////////////////////
    // Data memory
    ////////////////////

    // Word addressed, byte offset bits ignored
    assign memIndex = exMem.aluResult[`DMEM_ADDR_WIDTH+1:2];
    assign loadData = dataMem[memIndex];

    always_ff @(posedge Clk) begin
        if (exMem.valid && exMem.memWrite) begin
            dataMem[memIndex] <= exMem.storeData;
        end
    end

    ////////////////////
    // MEM/WB register
    ////////////////////

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            wbWrite <= 1'b0;
        end else begin
            wbWrite <= exMem.valid && exMem.regWrite;
        end
    end

    always_ff @(posedge Clk) begin
        wbAluResult <= exMem.aluResult;
        wbReg       <= exMem.destReg;
        wbSelQ      <= exMem.wbSel;
        if (exMem.valid && exMem.memRead) begin
            wbLoadData <= loadData;
        end
    end

    // Writes to register 0 are dropped here
    assign wbValid = wbWrite && wbReg != '0;
    assign wbData  = (wbSelQ == 1'b1) ? wbLoadData : wbAluResult;

endmodule

// ==== source/pipeStageIf.sv ====
`timescale 1ns/1ps

// Decoder and register file outputs headed into execute
interface idExIf import pipelinePkg::*; ();
    logic    valid;
    aluOpT   aluOp;
    logic    aluSrc;
    shamtT   shamt;
    wordT    imm;
    wordT    readData1;
    wordT    readData2;
    regAddrT destReg;
    logic    regWrite;
    logic    memRead;
    logic    memWrite;
    wbSelT   wbSel;

    modport source (
        output valid, aluOp, aluSrc, shamt, imm,
        output readData1, readData2,
        output destReg, regWrite, memRead, memWrite, wbSel
    );

    modport sink (
        input valid, aluOp, aluSrc, shamt, imm,
        input readData1, readData2,
        input destReg, regWrite, memRead, memWrite, wbSel
    );
endinterface

// Contents of the EX/MEM register
interface exMemIf import pipelinePkg::*; ();
    logic    valid;
    wordT    aluResult;
    wordT    storeData;
    regAddrT destReg;
    logic    regWrite;
    logic    memRead;
    logic    memWrite;
    wbSelT   wbSel;

    modport source (
        output valid, aluResult, storeData, destReg, regWrite, memRead, memWrite, wbSel
    );

    modport sink (
        input valid, aluResult, storeData, destReg, regWrite, memRead, memWrite, wbSel
    );
endinterface

// ==== source/pipelinePkg.sv ====
`include "pipeline_settings.svh"

package pipelinePkg;

    ////////////////////
    // Datapath types
    ////////////////////

    // Data or instruction word
    typedef logic [`DATA_WIDTH-1:0] wordT;

    // Index into the register file
    typedef logic [`REG_ADDR_WIDTH-1:0] regAddrT;

    ////////////////////
    // Control types
    ////////////////////

    typedef logic [`ALU_OP_WIDTH-1:0] aluOpT;

    typedef logic [`SHAMT_WIDTH-1:0] shamtT;

    // 0 takes the ALU result, 1 takes the loaded word
    typedef logic wbSelT;

endpackage

// ==== source/pipeline_settings.svh ====
`ifndef PIPELINE_SETTINGS_SVH
`define PIPELINE_SETTINGS_SVH

// Datapath widths
`define DATA_WIDTH       32
`define REG_ADDR_WIDTH   5
`define SHAMT_WIDTH      5
`define ALU_OP_WIDTH     4
// 64-word data memory
`define DMEM_ADDR_WIDTH  6

// Primary opcodes, MIPS encodings
`define OP_RTYPE  6'b000000
`define OP_ADDI   6'b001000
`define OP_SLTI   6'b001010
`define OP_ANDI   6'b001100
`define OP_ORI    6'b001101
`define OP_LW     6'b100011
`define OP_SW     6'b101011

// R-type function field
`define FUNCT_SLL  6'b000000
`define FUNCT_ADD  6'b100000
`define FUNCT_SUB  6'b100010
`define FUNCT_AND  6'b100100
`define FUNCT_OR   6'b100101
`define FUNCT_SLT  6'b101010

// ALU operation select
`define ALU_AND  4'b0000
`define ALU_OR   4'b0001
`define ALU_ADD  4'b0010
`define ALU_SUB  4'b0110
`define ALU_SLT  4'b0111
`define ALU_SLL  4'b1000

`endif

// ==== source/processorPipeline.sv ====
`timescale 1ns/1ps

module processorPipeline
    import pipelinePkg::*;
(
    input  logic    Clk,
    input  logic    arstN,
    input  logic    instrValid,
    input  wordT    instr,
    output logic    wbValid,
    output regAddrT wbReg,
    output wordT    wbData
);

    idExIf  idEx ();
    exMemIf exMem ();

    regAddrT rsAddr;
    regAddrT rtAddr;

    assign rsAddr = instr[25:21];
    assign rtAddr = instr[20:16];

    // Decode and register read run side by side
    controlDecoder u_decoder (
        .instr      (instr),
        .ctrl       (idEx.source),
        .instrValid (instrValid)
    );

    registerFile u_regFile (
        .Clk       (Clk),
        .arstN     (arstN),
        .readAddr1 (rsAddr),
        .readAddr2 (rtAddr),
        .readData1 (idEx.readData1),
        .readData2 (idEx.readData2),
        .writeEn   (wbValid),
        .writeAddr (wbReg),
        .writeData (wbData)
    );

    executeStage u_execute (
        .Clk   (Clk),
        .arstN (arstN),
        .dec   (idEx.sink),
        .exMem (exMem.source)
    );

    memoryStage u_memory (
        .Clk     (Clk),
        .arstN   (arstN),
        .exMem   (exMem.sink),
        .wbValid (wbValid),
        .wbReg   (wbReg),
        .wbData  (wbData)
    );

endmodule

// ==== source/registerFile.sv ====
`timescale 1ns/1ps
`include "pipeline_settings.svh"

module registerFile
    import pipelinePkg::*;
(
    input  logic    Clk,
    input  logic    arstN,
    input  regAddrT readAddr1,
    input  regAddrT readAddr2,
    output wordT    readData1,
    output wordT    readData2,
    input  logic    writeEn,
    input  regAddrT writeAddr,
    input  wordT    writeData
);

    wordT regs [0:(2**`REG_ADDR_WIDTH)-1];

    // Register 0 keeps its reset value forever
    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 2**`REG_ADDR_WIDTH; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && writeAddr != '0) begin
            regs[writeAddr] <= writeData;
        end
    end

    // Same-cycle write shows up on the read port
    function automatic wordT readPort(regAddrT addr);
        if (writeEn && addr == writeAddr && addr != '0) begin
            return writeData;
        end
        return regs[addr];
    endfunction

    always_comb begin
        readData1 = readPort(readAddr1);
        readData2 = readPort(readAddr2);
    end

endmodule

// ==== test/processorPipelineTb.sv ====
`timescale 1ns/1ps
`include "pipeline_settings.svh"

module processorPipelineTb
    import pipelinePkg::*;
();

    localparam int CLK_PERIOD  = 10;
    localparam int SEED_COUNT  = 31;
    localparam int RAND_R      = 60;
    localparam int RAND_I      = 60;
    localparam int MEM_PAIRS   = 16;
    localparam int DIRECTED    = 22;
    localparam int ISSUE_COUNT = SEED_COUNT + RAND_R + RAND_I + 2 * MEM_PAIRS + DIRECTED;
    // Worst case is three idle cycles ahead of every strobe
    localparam int WATCHDOG_NS = (ISSUE_COUNT * 4 + 5 + 60) * CLK_PERIOD;

    logic    Clk;
    logic    arstN;
    logic    instrValid;
    wordT    instr;
    logic    wbValid;
    regAddrT wbReg;
    wordT    wbData;

    wordT        modelRegs [0:(2**`REG_ADDR_WIDTH)-1];
    wordT        modelMem [0:(2**`DMEM_ADDR_WIDTH)-1];
    int          lastWrite [0:(2**`REG_ADDR_WIDTH)-1];
    int          cycleCount = 0;
    logic [15:0] lfsrState = 16'd28885;
    logic [5:0]  functTable [0:5] = '{`FUNCT_ADD, `FUNCT_SUB, `FUNCT_AND,
                                      `FUNCT_OR, `FUNCT_SLT, `FUNCT_SLL};
    logic [5:0]  opTable [0:3] = '{`OP_ADDI, `OP_SLTI, `OP_ANDI, `OP_ORI};

    // Expected write-backs in issue order, with the strobe cycle
    regAddrT expReg [$];
    wordT    expData [$];
    int      expCycle [$];

    processorPipeline u_dut (
        .Clk        (Clk),
        .arstN      (arstN),
        .instrValid (instrValid),
        .instr      (instr),
        .wbValid    (wbValid),
        .wbReg      (wbReg),
        .wbData     (wbData)
    );

    initial begin
        Clk = 1'b0;
        forever #(CLK_PERIOD/2) Clk = ~Clk;
    end

    always @(posedge Clk) begin
        cycleCount <= cycleCount + 1;
    end

    ////////////////////
    // Helpers
    ////////////////////

    // 16-bit Galois LFSR, one step per bit
    function automatic logic [31:0] randBits(input int count);
        logic [31:0] result;
        logic        outBit;
        result = '0;
        for (int i = 0; i < count; i++) begin
            outBit = lfsrState[0];
            lfsrState = lfsrState >> 1;
            if (outBit) begin
                lfsrState = lfsrState ^ 16'hB400;
            end
            result = {result[30:0], outBit};
        end
        return result;
    endfunction

    function automatic wordT encodeR(input logic [5:0] funct, input regAddrT rd,
                                     input regAddrT rs, input regAddrT rt, input shamtT shamt);
        return {`OP_RTYPE, rs, rt, rd, shamt, funct};
    endfunction

    function automatic wordT encodeI(input logic [5:0] op, input regAddrT rt,
                                     input regAddrT rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // Reference model, returns 1 when a nonzero register is written
    function automatic logic modelExecute(input wordT ins, output regAddrT dest,
                                          output wordT value);
        logic [5:0] op;
        logic [5:0] funct;
        wordT       a;
        wordT       b;
        wordT       immSigned;
        wordT       immZero;
        wordT       addr;
        logic       writes;
        op = ins[31:26];
        funct = ins[5:0];
        a = modelRegs[ins[25:21]];
        b = modelRegs[ins[20:16]];
        immSigned = {{16{ins[15]}}, ins[15:0]};
        immZero = {16'h0000, ins[15:0]};
        addr = a + immSigned;
        dest = ins[20:16];
        value = '0;
        writes = 1'b1;
        case (op)
            `OP_RTYPE: begin
                dest = ins[15:11];
                case (funct)
                    `FUNCT_ADD: value = a + b;
                    `FUNCT_SUB: value = a - b;
                    `FUNCT_AND: value = a & b;
                    `FUNCT_OR:  value = a | b;
                    `FUNCT_SLT: value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    `FUNCT_SLL: value = b << ins[10:6];
                    default:    writes = 1'b0;
                endcase
            end
            `OP_ADDI: value = a + immSigned;
            `OP_SLTI: value = ($signed(a) < $signed(immSigned)) ? 32'd1 : 32'd0;
            `OP_ANDI: value = a & immZero;
            `OP_ORI:  value = a | immZero;
            `OP_LW:   value = modelMem[addr[`DMEM_ADDR_WIDTH+1:2]];
            `OP_SW: begin
                modelMem[addr[`DMEM_ADDR_WIDTH+1:2]] = b;
                writes = 1'b0;
            end
            default: writes = 1'b0;
        endcase
        if (writes && dest != '0) begin
            modelRegs[dest] = value;
            return 1'b1;
        end
        return 1'b0;
    endfunction

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic compareValue(input string name, input logic [31:0] actual,
                                input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERR %s: got 0x%08h, expected 0x%08h", name, actual, expected);
            abortRun("mismatch on a DUT output");
        end
    endtask

    task automatic idleCycles(input int count);
        repeat (count) begin
            @(negedge Clk);
            instrValid = 1'b0;
            instr = '0;
        end
    endtask

    // Waits out producers that are fewer than three cycles old
    task automatic issue(input wordT ins);
        logic [5:0] op;
        regAddrT    rs;
        regAddrT    rt;
        regAddrT    dest;
        wordT       value;
        logic       readsRt;
        op = ins[31:26];
        rs = ins[25:21];
        rt = ins[20:16];
        readsRt = (op == `OP_RTYPE) || (op == `OP_SW);
        @(negedge Clk);
        while (cycleCount < lastWrite[rs] + 3 ||
               (readsRt && cycleCount < lastWrite[rt] + 3)) begin
            instrValid = 1'b0;
            instr = '0;
            @(negedge Clk);
        end
        instrValid = 1'b1;
        instr = ins;
        if (modelExecute(ins, dest, value)) begin
            expReg.push_back(dest);
            expData.push_back(value);
            expCycle.push_back(cycleCount);
            lastWrite[dest] = cycleCount;
        end
    endtask

    ////////////////////
    // Checker and watchdog
    ////////////////////

    always @(posedge Clk) begin
        if (arstN && wbValid) begin
            if (expReg.size() == 0) begin
                abortRun("wbValid was asserted while no result was outstanding");
            end else begin
                compareValue("wbReg", wbReg, expReg.pop_front());
                compareValue("wbData", wbData, expData.pop_front());
                compareValue("wbLatency", cycleCount - expCycle.pop_front(), 3);
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        abortRun("watchdog expired before the instruction stream completed");
    end

    ////////////////////
    // Stimulus
    ////////////////////

    initial begin
        regAddrT rd;
        regAddrT rs;
        regAddrT rt;
        int      idx;
        int      loadIdx;
        int      storedList [$];
        instrValid = 1'b0;
        instr = '0;
        arstN = 1'b0;
        for (int r = 0; r < 2**`REG_ADDR_WIDTH; r++) begin
            modelRegs[r] = '0;
            lastWrite[r] = -100;
        end
        repeat (5) @(posedge Clk);
        @(negedge Clk);
        arstN = 1'b1;

        // Quiet after reset, then fresh registers read as zero
        repeat (8) begin
            @(negedge Clk);
            compareValue("wbValid", wbValid, 1'b0);
        end
        for (int k = 0; k < 4; k++) begin
            issue(encodeR(`FUNCT_OR, k + 1, k + 5, 0, 0));
        end

        for (int r = 1; r <= SEED_COUNT; r++) begin
            issue(encodeI(`OP_ADDI, r, 0, randBits(16)));
        end

        for (int k = 0; k < RAND_R; k++) begin
            rd = randBits(5);
            if (rd == 0) begin
                rd = 31;
            end
            rs = randBits(5);
            rt = randBits(5);
            issue(encodeR(functTable[randBits(3) % 6], rd, rs, rt, randBits(5)));
        end

        for (int k = 0; k < RAND_I; k++) begin
            rt = randBits(5);
            if (rt == 0) begin
                rt = 30;
            end
            rs = randBits(5);
            issue(encodeI(opTable[randBits(2)], rt, rs, randBits(16)));
        end
        // Immediates with bit 15 set
        issue(encodeI(`OP_ORI, 11, 0, 16'hFFFF));
        issue(encodeI(`OP_ADDI, 12, 0, 16'hFFFF));
        issue(encodeI(`OP_ANDI, 10, 12, 16'h8000));
        issue(encodeI(`OP_SLTI, 13, 12, 16'h8000));
        issue(encodeI(`OP_SLTI, 14, 0, 16'h0001));

        // Store then load, even pairs hit the word just stored
        for (int p = 0; p < MEM_PAIRS; p++) begin
            idx = randBits(6);
            storedList.push_back(idx);
            rt = randBits(5);
            issue(encodeI(`OP_SW, rt, 0, 16'(idx * 4)));
            if (p % 2 == 0) begin
                loadIdx = idx;
            end else begin
                loadIdx = storedList[randBits(6) % storedList.size()];
            end
            rd = randBits(5);
            if (rd == 0) begin
                rd = 29;
            end
            issue(encodeI(`OP_LW, rd, 0, 16'(loadIdx * 4)));
        end

        // r0 targets and undefined encodings retire silently
        issue(encodeI(`OP_ADDI, 0, 0, 16'h1234));
        issue(encodeR(`FUNCT_ADD, 0, 1, 2, 0));
        issue(encodeI(6'b111111, 5, 0, 16'h0042));
        issue(encodeR(6'b000001, 6, 1, 2, 0));
        issue(encodeR(`FUNCT_OR, 9, 0, 0, 0));

        // Independent instructions on consecutive cycles
        for (int k = 0; k < 8; k++) begin
            issue(encodeI(`OP_ADDI, 20 + k, 0, randBits(16)));
        end

        // Longer than the three-cycle latency
        idleCycles(6);
        if (expReg.size() != 0) begin
            abortRun($sformatf("%0d expected results never appeared", expReg.size()));
        end else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule
